/* bench/div_ref_model.svh */
`ifndef DIV_REF_MODEL_SVH
`define DIV_REF_MODEL_SVH

// Exact unsigned division, valid only for in-range operands
function automatic quot_t exact_quot(input dividend_t n, input divisor_t d);
  return quot_t'(n / dividend_t'(d));
endfunction

function automatic rem_t exact_rem(input dividend_t n, input divisor_t d);
  return rem_t'(n % dividend_t'(d));
endfunction

// One subtract cell, result is {borrow, difference}
function automatic logic [1:0] cell_sub(input logic x, input logic y, input logic bin,
                                        input logic apx);
  logic df;
  logic bo;
  if (apx) begin
    bo = (!x && y) || (!x && !y && bin) || (x && y && bin);
    df = (x && !y) || (x && y && bin);
  end else begin
    df = x ^ y ^ bin;
    bo = (!x && y) || (!(x ^ y) && bin);
  end
  return {bo, df};
endfunction

// Restoring array, one row per quotient bit from the top; returns {quotient, remainder}
function automatic logic [15:0] array_model(input dividend_t n, input divisor_t d,
                                            input logic approx_en);
  logic [7:0] x;
  logic [7:0] r;
  logic [7:0] diff;
  logic [1:0] c;
  logic       spill;
  logic       b;
  logic       apx;
  quot_t      q;
  r = n[15:8];
  for (int i = `DIV_D_W - 1; i >= 0; i--) begin
    x     = {r[6:0], n[i]};  // Shift in the next dividend bit
    spill = r[7];
    apx   = approx_en && (i < `DIV_APPROX_ROWS);
    b     = 1'b0;
    for (int j = 0; j < `DIV_D_W; j++) begin
      c       = cell_sub(x[j], d[j], b, apx);
      diff[j] = c[0];
      b       = c[1];
    end
    q[i] = spill | ~b;
    r    = q[i] ? diff : x;
  end
  return {q, r};
endfunction

`endif

/* bench/tb_approx_divider.sv */
`timescale 1ns/1ps
`default_nettype none

`include "div_consts.svh"

module tb_approx_divider;
  import div_pkg::*;

  `include "div_ref_model.svh"

  localparam int N_DIRECTED = 12;
  localparam int N_RANDOM   = 40;
  localparam int TABLE_LEN  = N_DIRECTED + N_RANDOM;
  localparam int RESET_CYC  = 4;
  localparam int CYCLE_LIMIT = TABLE_LEN + RESET_CYC + 20;

  typedef struct packed {
    dividend_t n;
    divisor_t  d;
    logic      apx;
    quot_t     q;
    rem_t      r;
    logic      zero;
    logic      ovf;
  } entry_t;

  logic      clk = 1'b0;
  logic      rst_n;
  logic      in_valid;
  dividend_t in_dividend;
  divisor_t  in_divisor;
  logic      in_approx_en;
  logic      out_valid;
  quot_t     out_quotient;
  rem_t      out_remainder;
  logic      out_div_zero;
  logic      out_overflow;

  entry_t      tbl [TABLE_LEN];
  int          idx_q [$];
  int          issue_q [$];
  int          cycle = 0;
  int          cycles_run = 0;
  int          err_value = 0;
  int          err_timing = 0;
  int          err_proto = 0;
  int          approx_diffs = 0;
  logic [31:0] lcg_state = 32'hc530e45d;

  approx_divider_top DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_valid      (in_valid),
    .in_dividend   (in_dividend),
    .in_divisor    (in_divisor),
    .in_approx_en  (in_approx_en),
    .out_valid     (out_valid),
    .out_quotient  (out_quotient),
    .out_remainder (out_remainder),
    .out_div_zero  (out_div_zero),
    .out_overflow  (out_overflow)
  );

  initial begin
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Expected values from the flag rules and the exact or bit-level model
  task automatic set_entry(input int idx, input dividend_t n, input divisor_t d,
                           input logic apx);
    logic [15:0] m;
    tbl[idx].n    = n;
    tbl[idx].d    = d;
    tbl[idx].apx  = apx;
    tbl[idx].zero = (d == 8'd0);
    tbl[idx].ovf  = (d != 8'd0) && (n[15:8] >= d);
    if (tbl[idx].zero || tbl[idx].ovf) begin
      tbl[idx].q = '1;  // Saturated
      tbl[idx].r = '0;
    end else if (apx) begin
      m          = array_model(n, d, 1'b1);
      tbl[idx].q = m[15:8];
      tbl[idx].r = m[7:0];
      if (m[15:8] != exact_quot(n, d) || m[7:0] != exact_rem(n, d))
        approx_diffs++;
    end else begin
      tbl[idx].q = exact_quot(n, d);
      tbl[idx].r = exact_rem(n, d);
    end
  endtask

  task automatic build_table();
    logic [31:0] rnd;
    divisor_t    d;
    logic [7:0]  hi;
    set_entry(0, 16'd1000, 8'd7, 1'b0);
    set_entry(1, 16'hfeff, 8'hff, 1'b0);
    set_entry(2, 16'd0, 8'd5, 1'b0);
    set_entry(3, 16'd1000, 8'd7, 1'b1);
    set_entry(4, 16'hfeff, 8'hff, 1'b1);
    set_entry(5, 16'h1234, 8'h35, 1'b1);
    set_entry(6, 16'd1234, 8'd0, 1'b0);  // Divide by zero
    set_entry(7, 16'habcd, 8'd0, 1'b1);
    set_entry(8, 16'h1000, 8'h10, 1'b0); // Upper byte equals divisor
    set_entry(9, 16'hffff, 8'h01, 1'b1);
    set_entry(10, 16'h00ff, 8'h01, 1'b0);
    set_entry(11, 16'h7fff, 8'h80, 1'b0);
    for (int k = N_DIRECTED; k < TABLE_LEN; k++) begin
      rnd = next_rand();
      d   = rnd[23:16];
      hi  = rnd[15:8];
      // About one in eight keeps a raw upper byte
      if (rnd[31:29] != 3'd0 && d != 8'd0)
        hi = hi % d;
      set_entry(k, {hi, rnd[7:0]}, d, rnd[28]);
    end
  endtask

  task automatic check_quot(input quot_t got, input quot_t exp, input int idx);
    if (got !== exp) begin
      $display("** Error at %0t ns: entry %0d quotient %h, expected %h", $time, idx, got, exp);
      err_value++;
    end
  endtask

  // Remainder together with both flags
  task automatic check_rem(input rem_t got, input logic got_zero, input logic got_ovf,
                           input rem_t exp, input logic exp_zero, input logic exp_ovf,
                           input int idx);
    if (got !== exp || got_zero !== exp_zero || got_ovf !== exp_ovf) begin
      $display("** Error at %0t ns: entry %0d rem %h zero %b ovf %b, expected %h %b %b",
               $time, idx, got, got_zero, got_ovf, exp, exp_zero, exp_ovf);
      err_value++;
    end
  endtask

  task automatic finish_run();
    int total;
    total = err_value + err_timing + err_proto;
    $display("Error counts: value %0d, timing %0d, protocol %0d, total %0d; approx off exact %0d",
             err_value, err_timing, err_proto, total, approx_diffs);
    if (total == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  endtask

  initial begin
    rst_n        <= 1'b0;
    in_valid     <= 1'b0;
    in_dividend  <= '0;
    in_divisor   <= '0;
    in_approx_en <= 1'b0;
    build_table();
    repeat (RESET_CYC) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);  // Idle cycles keep out_valid low
    for (int k = 0; k < TABLE_LEN; k++) begin
      @(posedge clk);
      in_valid     <= 1'b1;
      in_dividend  <= tbl[k].n;
      in_divisor   <= tbl[k].d;
      in_approx_en <= tbl[k].apx;
      idx_q.push_back(k);
      issue_q.push_back(cycle);
    end
    @(posedge clk);
    in_valid <= 1'b0;
    while (idx_q.size() != 0)
      @(posedge clk);
    repeat (4) @(posedge clk);
    finish_run();
  end

  // Sampled on the falling edge two cycles after the drive
  always @(negedge clk) begin : monitor
    int k;
    int issued;
    if (out_valid === 1'b1) begin
      if (idx_q.size() == 0) begin
        $display("Unexpected out_valid at %0t ns with no operation pending", $time);
        err_proto++;
      end else begin
        k      = idx_q.pop_front();
        issued = issue_q.pop_front();
        if (cycle - issued != 2) begin
          $display("** Error at %0t ns: entry %0d took %0d cycles, expected 2",
                   $time, k, cycle - issued);
          err_timing++;
        end
        check_quot(out_quotient, tbl[k].q, k);
        check_rem(out_remainder, out_div_zero, out_overflow,
                  tbl[k].r, tbl[k].zero, tbl[k].ovf, k);
      end
    end else if (out_valid !== 1'b0) begin
      $display("out_valid is unknown at %0t ns", $time);
      err_proto++;
    end
    cycle++;
  end

  always @(posedge clk) begin
    cycles_run <= cycles_run + 1;
    if (cycles_run >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, %0d results never got out_valid",
               cycles_run, idx_q.size());
      err_proto++;
      finish_run();
    end
  end

endmodule

`default_nettype wire

/* design/approx_divider_top.sv */
`timescale 1ns/1ps
`default_nettype none

module approx_divider_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in_valid,
  input  div_pkg::dividend_t in_dividend,
  input  div_pkg::divisor_t  in_divisor,
  input  logic               in_approx_en,
  output logic               out_valid,
  output div_pkg::quot_t     out_quotient,
  output div_pkg::rem_t      out_remainder,
  output logic               out_div_zero,
  output logic               out_overflow
);

  div_operand_if ops_if (.clk(clk));
  div_result_if  res_if ();

  // Stage 1, operands and flags
  div_operand_capture u_capture (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (in_valid),
    .in_dividend  (in_dividend),
    .in_divisor   (in_divisor),
    .in_approx_en (in_approx_en),
    .ops          (ops_if)
  );

  div_array u_array (
    .ops (ops_if),
    .res (res_if)
  );

  // Stage 2, saturation and output hold
  div_result_stage u_result (
    .clk           (clk),
    .rst_n         (rst_n),
    .ops           (ops_if),
    .res           (res_if),
    .out_valid     (out_valid),
    .out_quotient  (out_quotient),
    .out_remainder (out_remainder),
    .out_div_zero  (out_div_zero),
    .out_overflow  (out_overflow)
  );

endmodule

`default_nettype wire

/* design/div_array.sv */
`timescale 1ns/1ps
`default_nettype none

`include "div_consts.svh"

module div_array #(
  parameter int approx_rows = `DIV_APPROX_ROWS
) (
  div_operand_if.sink ops,
  div_result_if.src   res
);
  import div_pkg::*;

  localparam int D_W = `DIV_D_W;

  logic [D_W-1:0] r_loc [D_W];  // Partial remainder out of each row
  logic [D_W-1:0] bout  [D_W];  // Borrow chain per row
  quot_t          q;

  if (approx_rows < 0 || approx_rows > D_W) begin : g_bad_rows
    $error("approx_rows out of range");
  end

  for (genvar i = 0; i < D_W; i++) begin : g_row
    logic row_approx;

    if (i < approx_rows) begin : g_apx
      assign row_approx = ops.approx_en;
    end else begin : g_ext
      assign row_approx = 1'b0;
    end

    for (genvar j = 0; j < D_W; j++) begin : g_col
      logic x_in;
      logic b_in;

      if (j == 0) begin : g_first
        assign x_in = ops.dividend[i];  // Fresh dividend bit
        assign b_in = 1'b0;
      end else if (i == D_W-1) begin : g_top
        assign x_in = ops.dividend[D_W-1+j];
        assign b_in = bout[i][j-1];
      end else begin : g_mid
        // Shifted remainder from the row above
        assign x_in = r_loc[i+1][j-1];
        assign b_in = bout[i][j-1];
      end

      div_cell u_cell (
        .x      (x_in),
        .y      (ops.divisor[j]),
        .bin    (b_in),
        .qs     (q[i]),
        .approx (row_approx),
        .r_sub  (r_loc[i][j]),
        .bout   (bout[i][j])
      );
    end

    // Quotient bit is set if the spilled MSB was 1 or no borrow came out
    if (i == D_W-1) begin : g_qtop
      assign q[i] = ops.dividend[`DIV_N_W-1] | ~bout[i][D_W-1];
    end else begin : g_qmid
      assign q[i] = r_loc[i+1][D_W-1] | ~bout[i][D_W-1];
    end
  end

  assign res.quotient  = q;
  assign res.remainder = r_loc[0];

  // Exact rows must satisfy q*d + r == n for in-range operands
  a_exact_identity: assert property (@(posedge ops.clk)
    (ops.valid && !ops.approx_en && !ops.div_zero && !ops.overflow) |->
    (dividend_t'(res.quotient) * dividend_t'(ops.divisor) + dividend_t'(res.remainder)
      == ops.dividend));

endmodule

`default_nettype wire

/* design/div_cell.sv */
`timescale 1ns/1ps
`default_nettype none

module div_cell (
  input  logic x,
  input  logic y,
  input  logic bin,
  input  logic qs,
  input  logic approx,
  output logic r_sub,
  output logic bout
);

  logic diff_exact;
  logic diff_apx;
  logic diff;

  // Full subtract x - y - bin
  assign diff_exact = x ^ y ^ bin;
  assign bout       = (~x & y) | (~(x ^ y) & bin);  // Simplified borrow table is the same

  // Simplified difference that misses a few input triples
  assign diff_apx = (x & ~y) | (x & y & bin);

  assign diff  = approx ? diff_apx : diff_exact;

  // Restore x when the row's quotient bit is 0
  assign r_sub = qs ? diff : x;

endmodule

`default_nettype wire

/* design/div_consts.svh */
`ifndef DIV_CONSTS_SVH
`define DIV_CONSTS_SVH

// Dividend is twice the divisor width
`define DIV_N_W 16

// Divisor, quotient and remainder width
`define DIV_D_W 8

// Low quotient rows that may run approximate cells
`define DIV_APPROX_ROWS 2

`endif

/* design/div_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

// Registered operands plus their flags
interface div_operand_if (
  input logic clk
);
  import div_pkg::*;

  logic      valid;
  dividend_t dividend;
  divisor_t  divisor;
  logic      approx_en;
  logic      div_zero;
  logic      overflow;

  modport src (
    input  clk,
    output valid, dividend, divisor, approx_en, div_zero, overflow
  );

  modport sink (
    input clk, valid, dividend, divisor, approx_en, div_zero, overflow
  );
endinterface

// Raw array result, not yet saturated
interface div_result_if;
  import div_pkg::*;

  quot_t quotient;
  rem_t  remainder;

  modport src  (output quotient, remainder);
  modport sink (input  quotient, remainder);
endinterface

`default_nettype wire

/* design/div_operand_capture.sv */
`timescale 1ns/1ps
`default_nettype none

`include "div_consts.svh"

module div_operand_capture (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 in_valid,
  input  div_pkg::dividend_t   in_dividend,
  input  div_pkg::divisor_t    in_divisor,
  input  logic                 in_approx_en,
  div_operand_if.src           ops
);
  import div_pkg::*;

  divisor_t n_hi;
  logic     zero_next;
  logic     ovf_next;

  // Upper dividend byte must stay below the divisor
  assign n_hi      = in_dividend[`DIV_N_W-1 -: `DIV_D_W];
  assign zero_next = (in_divisor == '0);
  assign ovf_next  = !zero_next && (n_hi >= in_divisor);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ops.valid     <= 1'b0;
      ops.dividend  <= '0;
      ops.divisor   <= '0;
      ops.approx_en <= 1'b0;
      ops.div_zero  <= 1'b0;
      ops.overflow  <= 1'b0;
    end else begin
      ops.valid     <= in_valid;
      ops.dividend  <= in_dividend;
      ops.divisor   <= in_divisor;
      ops.approx_en <= in_approx_en;
      ops.div_zero  <= zero_next;
      ops.overflow  <= ovf_next;
    end
  end

  a_flags_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(ops.div_zero && ops.overflow));

endmodule

`default_nettype wire

/* design/div_pkg.sv */
`default_nettype none

`include "div_consts.svh"

package div_pkg;

  // Unsigned operands
  typedef logic [`DIV_N_W-1:0] dividend_t;
  typedef logic [`DIV_D_W-1:0] divisor_t;

  // Array outputs, one row per quotient bit
  typedef logic [`DIV_D_W-1:0] quot_t;
  typedef logic [`DIV_D_W-1:0] rem_t;

endpackage

`default_nettype wire

/* design/div_result_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module div_result_stage (
  input  logic           clk,
  input  logic           rst_n,
  div_operand_if.sink    ops,
  div_result_if.sink     res,
  output logic           out_valid,
  output div_pkg::quot_t out_quotient,
  output div_pkg::rem_t  out_remainder,
  output logic           out_div_zero,
  output logic           out_overflow
);
  import div_pkg::*;

  quot_t q_next;
  rem_t  r_next;
  logic  saturate;

  assign saturate = ops.div_zero || ops.overflow;

  // All ones quotient and zero remainder on either flag
  always_comb begin
    if (saturate) begin
      q_next = '1;
      r_next = '0;
    end else begin
      q_next = res.quotient;
      r_next = res.remainder;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid     <= 1'b0;
      out_quotient  <= '0;
      out_remainder <= '0;
      out_div_zero  <= 1'b0;
      out_overflow  <= 1'b0;
    end else begin
      out_valid <= ops.valid;
      if (ops.valid) begin  // Hold until the next result
        out_quotient  <= q_next;
        out_remainder <= r_next;
        out_div_zero  <= ops.div_zero;
        out_overflow  <= ops.overflow;
      end
    end
  end

  a_no_valid_after_reset: assert property (@(posedge clk) !rst_n |=> !out_valid);

endmodule

`default_nettype wire

/* project.f */
+incdir+design
+incdir+bench
design/div_pkg.sv
design/div_ifs.sv
design/div_operand_capture.sv
design/div_cell.sv
design/div_array.sv
design/div_result_stage.sv
design/approx_divider_top.sv
bench/tb_approx_divider.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the divider testbench with Verilator, run it, then scan the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  --top-module tb_approx_divider \
  -f project.f \
  -o sim_divider

./obj_dir/sim_divider > sim.log
cat sim.log

if grep -qx "NO ERRORS" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
